//--- Makefile
TOP := awe_rowbuffers_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f awe_rowbuffers.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- awe_rowbuffers.f
+incdir+design
design/awe_rowbuf_pkg.sv
design/pixel_ram.sv
design/prime_write_decode.sv
design/kernel_read_port.sv
design/ce_row_lane.sv
design/awe_rowbuffers.sv
bench/awe_rowbuffers_sva.sv
bench/awe_rowbuffers_tb.sv

//--- bench/awe_rowbuffers_sva.sv
`timescale 1ns/1ps
`include "awe_rowbuf_consts.svh"

module awe_rowbuffers_sva
    import awe_rowbuf_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input awe_mode_e   mode,
    input read_req_t   ce0_read,
    input read_req_t   ce1_read,
    input pixel_pair_t ce0_out,
    input pixel_pair_t ce1_out,
    input cycle_cnt_t  ce0_cycle_count,
    input cycle_cnt_t  ce1_cycle_count
);

    logic ce0_accept;
    logic ce1_accept;

    assign ce0_accept = ce0_read.strobe && (mode == mode_active);
    assign ce1_accept = ce1_read.strobe && (mode == mode_active);

    //////////////////////////////////////////////////
    // Read latency
    //////////////////////////////////////////////////

    // Valid is sampled one edge after it rises
    ce0_valid_after_read: assert property (@(posedge clk) disable iff (rst)
        ce0_accept |-> ##3 ce0_out.valid) else $error("ce0 read not followed by valid");
    ce1_valid_after_read: assert property (@(posedge clk) disable iff (rst)
        ce1_accept |-> ##4 ce1_out.valid) else $error("ce1 read not followed by valid");

    // No valid without a matching read
    ce0_valid_has_read: assert property (@(posedge clk) disable iff (rst)
        ce0_out.valid |-> $past(ce0_accept, 3)) else $error("ce0 valid without a read");
    ce1_valid_has_read: assert property (@(posedge clk) disable iff (rst)
        ce1_out.valid |-> $past(ce1_accept, 4)) else $error("ce1 valid without a read");

    ce0_count_range: assert property (@(posedge clk) disable iff (rst)
        ce0_cycle_count < cycle_cnt_t'(`AWE_CYCLE_MOD)) else $error("ce0 cycle count too big");
    ce1_count_range: assert property (@(posedge clk) disable iff (rst)
        ce1_cycle_count < cycle_cnt_t'(`AWE_CYCLE_MOD)) else $error("ce1 cycle count too big");

endmodule

bind awe_rowbuffers awe_rowbuffers_sva u_awe_rowbuffers_sva (
    .clk             (clk),
    .rst             (rst),
    .mode            (mode),
    .ce0_read        (ce0_read),
    .ce1_read        (ce1_read),
    .ce0_out         (ce0_out),
    .ce1_out         (ce1_out),
    .ce0_cycle_count (ce0_cycle_count),
    .ce1_cycle_count (ce1_cycle_count)
);

//--- bench/awe_rowbuffers_tb.sv
`timescale 1ns/1ps
`include "awe_rowbuf_consts.svh"

module awe_rowbuffers_tb
    import awe_rowbuf_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_COLS = 20;
    // Cycle budgets of the six tests
    localparam int TOTAL_CYCLES = 10 + 80 + 150 + 150 + 60 + 40;

    typedef struct packed {
        logic       pending;
        logic [1:0] row;
        col_t       col;
        pixel_t     data;
    } model_wr_t;

    logic        clk;
    logic        rst;
    awe_mode_e   mode;
    col_t        num_input_cols;
    pixel_t      pixel_in [2];
    prime_req_t  prime_req [2];
    read_req_t   read_req [2];
    pixel_pair_t dut_out [2];
    cycle_cnt_t  cycle_count [2];

    pixel_t      even_model [2][`AWE_BRAM_DEPTH];
    pixel_t      odd_model [2][`AWE_BRAM_DEPTH];
    model_wr_t   model_wr [2];
    pixel_pair_t exp_q [2][$];
    int          valid_seen [2] = '{0, 0};
    int          errors = 0;
    int          checks = 0;
    int          tests_done = 0;
    int          errors_before = 0;

    awe_rowbuffers u_awe_rowbuffers (
        .clk             (clk),
        .rst             (rst),
        .mode            (mode),
        .num_input_cols  (num_input_cols),
        .ce0_pixel_in    (pixel_in[0]),
        .ce0_prime       (prime_req[0]),
        .ce0_read        (read_req[0]),
        .ce0_out         (dut_out[0]),
        .ce0_cycle_count (cycle_count[0]),
        .ce1_pixel_in    (pixel_in[1]),
        .ce1_prime       (prime_req[1]),
        .ce1_read        (read_req[1]),
        .ce1_out         (dut_out[1]),
        .ce1_cycle_count (cycle_count[1])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reference model at the rising edge
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        pixel_pair_t exp_pair;
        for (int e = 0; e < 2; e++) begin
            // Write lands one cycle after its strobe
            if (model_wr[e].pending) begin
                case (model_wr[e].row)
                    2'd0: begin
                        even_model[e][{1'b0, model_wr[e].col}] = model_wr[e].data;
                        odd_model[e][{1'b0, model_wr[e].col}]  = model_wr[e].data;
                    end
                    2'd1: odd_model[e][{1'b1, model_wr[e].col}] = model_wr[e].data;
                    default: even_model[e][{1'b1, model_wr[e].col}] = model_wr[e].data;
                endcase
            end
            model_wr[e].pending = !rst && mode == mode_prime && prime_req[e].strobe &&
                                  prime_req[e].row <= 2'd2 &&
                                  prime_req[e].col <= num_input_cols;
            model_wr[e].row  = prime_req[e].row;
            model_wr[e].col  = prime_req[e].col;
            model_wr[e].data = pixel_in[e];
            if (!rst && mode == mode_active && read_req[e].strobe) begin
                exp_pair.valid      = 1'b1;
                exp_pair.odd_pixel  = odd_model[e][read_req[e].odd_addr];
                exp_pair.even_pixel = even_model[e][read_req[e].even_addr];
                exp_q[e].push_back(exp_pair);
            end
        end
    end

    //////////////////////////////////////////////////
    // Output checks at the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        pixel_pair_t head;
        cycle_cnt_t  exp_count;
        if (rst) begin
            valid_seen = '{0, 0};
        end else begin
            for (int e = 0; e < 2; e++) begin
                exp_count = cycle_cnt_t'(valid_seen[e] % `AWE_CYCLE_MOD);
                checks++;
                assert (cycle_count[e] == exp_count) else begin
                    $display("MISMATCH ce%0d_cycle_count got %h exp %h",
                             e, cycle_count[e], exp_count);
                    errors++;
                end
                if (dut_out[e].valid) begin
                    valid_seen[e]++;
                    checks++;
                    assert (exp_q[e].size() > 0) else begin
                        $display("ce%0d raised valid with no read pending", e);
                        errors++;
                    end
                    if (exp_q[e].size() > 0) begin
                        head = exp_q[e].pop_front();
                        compare_pixel($sformatf("ce%0d_out.even_pixel", e),
                                      dut_out[e].even_pixel, head.even_pixel);
                        compare_pixel($sformatf("ce%0d_out.odd_pixel", e),
                                      dut_out[e].odd_pixel, head.odd_pixel);
                    end
                end
            end
        end
    end

    task automatic compare_pixel(input string sig, input pixel_t got, input pixel_t exp_val);
        checks++;
        assert (got === exp_val) else begin
            $display("MISMATCH %s got %h exp %h", sig, got, exp_val);
            errors++;
        end
    endtask

    // Four cycles in reset with idle outputs during and just after
    task automatic apply_reset();
        rst = 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            for (int e = 0; e < 2; e++) begin
                checks++;
                assert (!dut_out[e].valid) else begin
                    $display("MISMATCH ce%0d_out.valid got %h exp 0", e, dut_out[e].valid);
                    errors++;
                end
                checks++;
                assert (cycle_count[e] == '0) else begin
                    $display("MISMATCH ce%0d_cycle_count got %h exp 0", e, cycle_count[e]);
                    errors++;
                end
            end
            if (i == 3) begin
                rst = 1'b0;
            end
        end
    endtask

    task automatic set_mode(input awe_mode_e m, input int cols);
        @(negedge clk);
        mode = m;
        num_input_cols = col_t'(cols);
    endtask

    // Last pass drops the strobe
    task automatic prime_row(input logic [1:0] row_sel, input int first_col, input int last_col);
        for (int c = first_col; c <= last_col + 1; c++) begin
            @(negedge clk);
            for (int e = 0; e < 2; e++) begin
                prime_req[e] = '{strobe: (c <= last_col), row: row_sel, col: col_t'(c)};
                pixel_in[e] = pixel_t'($urandom);
            end
        end
    endtask

    task automatic read_range(input logic hi, input int first_col, input int last_col,
                              input bit spaced);
        for (int c = first_col; c <= last_col + 1; c++) begin
            @(negedge clk);
            for (int e = 0; e < 2; e++) begin
                read_req[e] = '{strobe: (c <= last_col), even_addr: {hi, col_t'(c)},
                                odd_addr: {hi, col_t'(c)}};
            end
            if (spaced) begin
                @(negedge clk);
                read_req[0].strobe = 1'b0;
                read_req[1].strobe = 1'b0;
            end
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q[0].size() + exp_q[1].size() > 0 && waited < 16) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (exp_q[0].size() + exp_q[1].size() == 0) else begin
            $display("Reads still waiting for valid after %0d cycles", waited);
            errors++;
        end
        // Room for a stray valid
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("Test %0d %s: %0d errors", tests_done, name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        void'($urandom(92255));
        rst = 1'b1;
        mode = mode_idle;
        num_input_cols = '0;
        for (int e = 0; e < 2; e++) begin
            pixel_in[e] = '0;
            prime_req[e] = '0;
            read_req[e] = '0;
            model_wr[e] = '0;
        end

        apply_reset();
        finish_test("reset state");

        set_mode(mode_prime, NUM_COLS);
        prime_row(2'd0, 0, NUM_COLS);
        set_mode(mode_active, NUM_COLS);
        read_range(1'b0, 0, NUM_COLS, 1'b1);
        wait_for_drain();
        finish_test("row 0 priming");

        set_mode(mode_prime, NUM_COLS);
        prime_row(2'd1, 0, NUM_COLS);
        prime_row(2'd2, 0, NUM_COLS);
        set_mode(mode_active, NUM_COLS);
        read_range(1'b1, 0, NUM_COLS, 1'b1);
        read_range(1'b0, 0, NUM_COLS, 1'b1);
        wait_for_drain();
        finish_test("rows 1 and 2");

        // Columns past the limit, then priming while active
        set_mode(mode_prime, NUM_COLS / 2);
        prime_row(2'd0, NUM_COLS / 2 + 1, NUM_COLS);
        set_mode(mode_active, NUM_COLS);
        prime_row(2'd0, 0, NUM_COLS);
        // Reads outside the active phase
        set_mode(mode_prime, NUM_COLS);
        read_range(1'b0, 0, NUM_COLS, 1'b0);
        set_mode(mode_idle, NUM_COLS);
        read_range(1'b0, 0, NUM_COLS, 1'b0);
        wait_for_drain();
        set_mode(mode_active, NUM_COLS);
        read_range(1'b0, 0, NUM_COLS, 1'b1);
        wait_for_drain();
        finish_test("column limit and mode gating");

        read_range(1'b1, 0, NUM_COLS, 1'b0);
        read_range(1'b0, 0, NUM_COLS, 1'b0);
        wait_for_drain();
        finish_test("back-to-back reads");

        apply_reset();
        set_mode(mode_active, NUM_COLS);
        read_range(1'b0, 0, 11, 1'b0);
        wait_for_drain();
        for (int e = 0; e < 2; e++) begin
            checks++;
            assert (cycle_count[e] == cycle_cnt_t'(12 % `AWE_CYCLE_MOD)) else begin
                $display("MISMATCH ce%0d_cycle_count got %h exp %h",
                         e, cycle_count[e], cycle_cnt_t'(12 % `AWE_CYCLE_MOD));
                errors++;
            end
        end
        finish_test("cycle count wrap");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- design/awe_rowbuf_consts.svh
`ifndef AWE_ROWBUF_CONSTS_SVH
`define AWE_ROWBUF_CONSTS_SVH

//////////////////////////////////////////////////
// Pixel and bank geometry
//////////////////////////////////////////////////

`define AWE_PIXEL_WIDTH 16

// Words per bank
`define AWE_BRAM_DEPTH 64
`define AWE_BRAM_ADDR_WIDTH 6

// Top address bit picks the row half
`define AWE_COL_WIDTH 5

// Kernel read cycle period
`define AWE_CYCLE_MOD 5

`endif

//--- design/awe_rowbuf_pkg.sv
`include "awe_rowbuf_consts.svh"

package awe_rowbuf_pkg;

    typedef logic [`AWE_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`AWE_BRAM_ADDR_WIDTH-1:0] bram_addr_t;
    typedef logic [`AWE_COL_WIDTH-1:0] col_t;
    typedef logic [$clog2(`AWE_CYCLE_MOD)-1:0] cycle_cnt_t;

    // Controller phase seen by the row buffers
    typedef enum logic [1:0] {
        mode_idle   = 2'd0,
        mode_prime  = 2'd1,
        mode_active = 2'd2
    } awe_mode_e;

    //////////////////////////////////////////////////
    // Request and command bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       strobe;
        logic [1:0] row;
        col_t       col;
    } prime_req_t;

    typedef struct packed {
        logic       strobe;
        bram_addr_t even_addr;
        bram_addr_t odd_addr;
    } read_req_t;

    typedef struct packed {
        logic       wren;
        bram_addr_t addr;
        pixel_t     data;
    } bank_wr_t;

    // One lane result
    typedef struct packed {
        logic   valid;
        pixel_t odd_pixel;
        pixel_t even_pixel;
    } pixel_pair_t;

endpackage

//--- design/awe_rowbuffers.sv
`timescale 1ns/1ps

module awe_rowbuffers
    import awe_rowbuf_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Shared controls
    input  awe_mode_e   mode,
    input  col_t        num_input_cols,

    // Engine 0
    input  pixel_t      ce0_pixel_in,
    input  prime_req_t  ce0_prime,
    input  read_req_t   ce0_read,
    output pixel_pair_t ce0_out,
    output cycle_cnt_t  ce0_cycle_count,

    // Engine 1
    input  pixel_t      ce1_pixel_in,
    input  prime_req_t  ce1_prime,
    input  read_req_t   ce1_read,
    output pixel_pair_t ce1_out,
    output cycle_cnt_t  ce1_cycle_count
);

    //////////////////////////////////////////////////
    // Engine 0 lane
    //////////////////////////////////////////////////

    ce_row_lane #(
        .READ_DELAY (0)
    ) u_ce0_lane (
        .clk            (clk),
        .rst            (rst),
        .mode           (mode),
        .num_input_cols (num_input_cols),
        .pixel_in       (ce0_pixel_in),
        .prime          (ce0_prime),
        .read           (ce0_read),
        .pair           (ce0_out),
        .cycle_count    (ce0_cycle_count)
    );

    //////////////////////////////////////////////////
    // Engine 1 lane
    //////////////////////////////////////////////////

    // Engine 1 starts one cycle after engine 0
    ce_row_lane #(
        .READ_DELAY (1)
    ) u_ce1_lane (
        .clk            (clk),
        .rst            (rst),
        .mode           (mode),
        .num_input_cols (num_input_cols),
        .pixel_in       (ce1_pixel_in),
        .prime          (ce1_prime),
        .read           (ce1_read),
        .pair           (ce1_out),
        .cycle_count    (ce1_cycle_count)
    );

endmodule

//--- design/ce_row_lane.sv
`timescale 1ns/1ps

module ce_row_lane
    import awe_rowbuf_pkg::*;
#(
    parameter int READ_DELAY = 0
) (
    input  logic        clk,
    input  logic        rst,
    input  awe_mode_e   mode,
    input  col_t        num_input_cols,
    input  pixel_t      pixel_in,
    input  prime_req_t  prime,
    input  read_req_t   read,
    output pixel_pair_t pair,
    output cycle_cnt_t  cycle_count
);

    bank_wr_t   even_wr;
    bank_wr_t   odd_wr;
    logic       even_rden;
    logic       odd_rden;
    bram_addr_t even_addr;
    bram_addr_t odd_addr;
    pixel_t     even_data;
    pixel_t     odd_data;

    //////////////////////////////////////////////////
    // Priming path
    //////////////////////////////////////////////////

    prime_write_decode u_prime_write_decode (
        .clk            (clk),
        .rst            (rst),
        .mode           (mode),
        .num_input_cols (num_input_cols),
        .prime          (prime),
        .pixel_in       (pixel_in),
        .even_wr        (even_wr),
        .odd_wr         (odd_wr)
    );

    // Even bank holds rows 0 and 2
    pixel_ram u_even_bank (
        .clk     (clk),
        .wr      (even_wr),
        .rden    (even_rden),
        .rd_addr (even_addr),
        .rd_data (even_data)
    );

    // Odd bank holds rows 0 and 1
    pixel_ram u_odd_bank (
        .clk     (clk),
        .wr      (odd_wr),
        .rden    (odd_rden),
        .rd_addr (odd_addr),
        .rd_data (odd_data)
    );

    //////////////////////////////////////////////////
    // Kernel read path
    //////////////////////////////////////////////////

    kernel_read_port #(
        .READ_DELAY (READ_DELAY)
    ) u_kernel_read_port (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .read        (read),
        .even_rden   (even_rden),
        .odd_rden    (odd_rden),
        .even_addr   (even_addr),
        .odd_addr    (odd_addr),
        .even_data   (even_data),
        .odd_data    (odd_data),
        .pair        (pair),
        .cycle_count (cycle_count)
    );

endmodule

//--- design/kernel_read_port.sv
`timescale 1ns/1ps
`include "awe_rowbuf_consts.svh"

module kernel_read_port
    import awe_rowbuf_pkg::*;
#(
    parameter int READ_DELAY = 0
) (
    input  logic        clk,
    input  logic        rst,
    input  awe_mode_e   mode,
    input  read_req_t   read,
    output logic        even_rden,
    output logic        odd_rden,
    output bram_addr_t  even_addr,
    output bram_addr_t  odd_addr,
    input  pixel_t      even_data,
    input  pixel_t      odd_data,
    output pixel_pair_t pair,
    output cycle_cnt_t  cycle_count
);

    logic                        accept;
    logic [READ_DELAY:0]         stb_pipe;
    bram_addr_t [READ_DELAY:0]   even_pipe;
    bram_addr_t [READ_DELAY:0]   odd_pipe;
    logic                        rden_q;
    logic                        valid_q;
    bram_addr_t                  even_addr_q;
    bram_addr_t                  odd_addr_q;
    cycle_cnt_t                  cnt_q;

    assign accept = read.strobe && (mode == mode_active);

    //////////////////////////////////////////////////
    // Request register and delay line
    //////////////////////////////////////////////////

    // Stage 0 samples the strobe, the rest add the engine offset
    always_ff @(posedge clk) begin
        if (rst) begin
            stb_pipe <= '0;
        end else begin
            stb_pipe[0] <= accept;
            for (int i = 1; i <= READ_DELAY; i++) begin
                stb_pipe[i] <= stb_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        even_pipe[0] <= read.even_addr;
        odd_pipe[0]  <= read.odd_addr;
        for (int i = 1; i <= READ_DELAY; i++) begin
            even_pipe[i] <= even_pipe[i-1];
            odd_pipe[i]  <= odd_pipe[i-1];
        end
        even_addr_q <= even_pipe[READ_DELAY];
        odd_addr_q  <= odd_pipe[READ_DELAY];
    end

    //////////////////////////////////////////////////
    // Bank enable, valid and cycle count
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            rden_q  <= stb_pipe[READ_DELAY];
            // RAM data is out one cycle after the enable
            valid_q <= rden_q;
            if (valid_q) begin
                if (cnt_q == cycle_cnt_t'(`AWE_CYCLE_MOD - 1)) begin
                    cnt_q <= '0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign even_rden   = rden_q;
    assign odd_rden    = rden_q;
    assign even_addr   = even_addr_q;
    assign odd_addr    = odd_addr_q;
    assign cycle_count = cnt_q;

    assign pair = '{
        valid:      valid_q,
        odd_pixel:  odd_data,
        even_pixel: even_data
    };

endmodule

//--- design/pixel_ram.sv
`timescale 1ns/1ps
`include "awe_rowbuf_consts.svh"

module pixel_ram
    import awe_rowbuf_pkg::*;
(
    input  logic       clk,
    input  bank_wr_t   wr,
    input  logic       rden,
    input  bram_addr_t rd_addr,
    output pixel_t     rd_data
);

    pixel_t mem [`AWE_BRAM_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.wren) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read that holds the last word read
    always_ff @(posedge clk) begin
        if (rden) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- design/prime_write_decode.sv
`timescale 1ns/1ps

module prime_write_decode
    import awe_rowbuf_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  awe_mode_e  mode,
    input  col_t       num_input_cols,
    input  prime_req_t prime,
    input  pixel_t     pixel_in,
    output bank_wr_t   even_wr,
    output bank_wr_t   odd_wr
);

    logic       accept;
    logic       even_sel;
    logic       odd_sel;
    logic       even_wren_q;
    logic       odd_wren_q;
    bram_addr_t addr_q;
    pixel_t     data_q;

    //////////////////////////////////////////////////
    // Row to bank mapping
    //////////////////////////////////////////////////

    assign accept = prime.strobe && (mode == mode_prime) &&
                    (prime.col <= num_input_cols);

    // Row 0 lands in both banks, row 2 in even only, row 1 in odd only
    assign even_sel = (prime.row == 2'd0) || (prime.row == 2'd2);
    assign odd_sel  = (prime.row == 2'd0) || (prime.row == 2'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            even_wren_q <= 1'b0;
            odd_wren_q  <= 1'b0;
        end else begin
            even_wren_q <= accept && even_sel;
            odd_wren_q  <= accept && odd_sel;
        end
    end

    // Rows 1 and 2 go to the high half
    always_ff @(posedge clk) begin
        addr_q <= {prime.row != 2'd0, prime.col};
        data_q <= pixel_in;
    end

    //////////////////////////////////////////////////
    // Bank commands
    //////////////////////////////////////////////////

    assign even_wr = '{
        wren: even_wren_q,
        addr: addr_q,
        data: data_q
    };

    assign odd_wr = '{
        wren: odd_wren_q,
        addr: addr_q,
        data: data_q
    };

endmodule
